//--- design/boxcar_pkg.sv
package boxcar_pkg;

  // sample and window geometry
  localparam int SAMPLE_W  = 16;           // one unsigned input sample
  localparam int MAX_DEPTH = 32;           // longest delay line, one SRL32
  localparam int SUM_W     = SAMPLE_W + 5; // 32 full-scale samples fit without wrap
  localparam int COUNT_W   = $clog2(MAX_DEPTH + 1); // fill count 0..MAX_DEPTH

  // plain vectors for the widths that carry a meaning
  typedef logic [SAMPLE_W-1:0] sample_t;   // unsigned sample
  typedef logic [SUM_W-1:0]    sum_t;      // unsigned running window sum
  typedef logic [COUNT_W-1:0]  count_t;    // samples currently in the window

  // one registered input cycle as seen by the buffer and the consumer
  // shift and flush are never high together, the producer makes sure of that
  typedef struct packed {
    logic    shift;                        // data enters the window this cycle
    logic    flush;                        // clear the whole window
    sample_t data;                         // sample to load into stage 0
  } capture_t;

  // capture_t must stay 18 bits wide
  // layout from msb: shift, flush, data[15:0]

  // DEPTH itself is a module parameter set at the top level,
  // legal range is 2 to MAX_DEPTH

  // the window sum is kept incrementally, so SUM_W only needs to
  // cover MAX_DEPTH * (2**SAMPLE_W - 1)

  // count_t holds MAX_DEPTH itself, hence the +1 in its width

  // all users reach these through boxcar_pkg:: scoped names

endpackage

//--- design/sample_capture.sv
`timescale 1ns/1ns

module sample_capture (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en,    // valid sample on din
  input  logic                clr,   // flush request, beats en
  input  boxcar_pkg::sample_t din,
  output boxcar_pkg::capture_t cap   // one registered input cycle
);

  boxcar_pkg::capture_t cap_d;       // next capture, built from the raw pins

  // combine the strobes so that at most one action reaches the
  // delay line and the sum in any cycle
  always_comb begin
    cap_d       = cap;               // default keeps the old data word
    cap_d.shift = en & ~clr;         // clr drops the sample of its own cycle
    cap_d.flush = clr;
    if (en) begin
      cap_d.data = din;              // only load data that is valid
    end
  end

  // input register stage
  // this isolates the filter from the outside timing and sets the
  // first of the two cycles of latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap <= '0;                     // no shift, no flush, zero data
    end else begin
      cap <= cap_d;
    end
  end

  // data holds its value while en is low
  // keeps the bus quiet on idle cycles, downstream ignores it anyway

  // strobes are single-cycle pulses here because en and clr are
  // resampled every edge

  // note: a cycle with both en and clr gives flush=1 shift=0

  // the struct fans out to both srl_delay and window_sum,
  // they act on the same edge so their state never drifts apart

  // nothing else is registered here, the struct is the whole output

  // reset clears the struct so that nothing shifts in right
  // after rst_n is released

  // din is unsigned, no sign handling anywhere downstream

endmodule

//--- design/srl_delay.sv
`timescale 1ns/1ns

module srl_delay #(
  parameter int DEPTH = 8                       // stages, 2..MAX_DEPTH
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  boxcar_pkg::capture_t cap,             // registered strobes and data
  output boxcar_pkg::sample_t  oldest,          // last stage, leaves on next shift
  output boxcar_pkg::sample_t  dout             // last stage to the top output
);

  localparam int W = boxcar_pkg::SAMPLE_W;      // width of one stage

  // all stages in one packed vector, stage 0 in the low bits
  // stage i sits at sr[i*W +: W]
  logic [DEPTH*W-1:0] sr;

  boxcar_pkg::sample_t last_stage;              // stage DEPTH-1

  // shift register with enable, like an SRL32 chain
  // flush wins, but the producer never sends both anyway
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sr <= '0;                                 // window starts empty
    end else if (cap.flush) begin
      sr <= '0;                                 // synchronous clear of every stage
    end else if (cap.shift) begin
      sr <= {sr[(DEPTH-1)*W-1:0], cap.data};    // move up one, new sample at 0
    end
  end

  // the last stage is the sample captured DEPTH-1 shifts ago
  assign last_stage = sr[DEPTH*W-1 -: W];

  // window_sum subtracts this on the same edge it shifts out
  assign oldest = last_stage;

  // same stage, already a register, so no extra latency on dout
  assign dout = last_stage;

  // zeros in the empty stages let the consumer subtract oldest
  // unconditionally, even while the window is still filling

  // no read port into the middle, tap selection is not supported

  // idle cycles (shift low) hold every stage, so dout is stable
  // between enabled samples

  // reset value matches the flush value, so the consumer's sum
  // and this line agree after either event

  // DEPTH times W flops in total, 512 at MAX_DEPTH

  // the packed layout also makes the whole line easy to probe
  // from a testbench as one vector

  // DEPTH below 2 would make the slice above empty

  // shift and flush come from the same capture struct that
  // window_sum sees, so both blocks change on the same edge

  // latency from cap to dout is one edge

endmodule

//--- design/window_sum.sv
`timescale 1ns/1ns

module window_sum #(
  parameter int DEPTH = 8                          // window length, 2..MAX_DEPTH
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  boxcar_pkg::capture_t cap,                // same capture as the delay line
  input  boxcar_pkg::sample_t  oldest,             // sample that leaves on this shift
  output boxcar_pkg::sum_t     sum,                // sum of all DEPTH stages
  output logic                 full                // window holds DEPTH real samples
);

  boxcar_pkg::count_t count;                       // shifts since reset or flush, saturating
  boxcar_pkg::sum_t   add_term;                    // incoming sample, zero extended
  boxcar_pkg::sum_t   sub_term;                    // leaving sample, zero extended
  boxcar_pkg::sum_t   sum_d;                       // sum after this shift
  logic               at_depth;                    // counter has reached DEPTH

  // incremental update, one adder and one subtractor instead
  // of a DEPTH input adder tree
  assign add_term = boxcar_pkg::sum_t'(cap.data);
  assign sub_term = boxcar_pkg::sum_t'(oldest);
  assign sum_d    = sum + add_term - sub_term;     // oldest is part of sum, no underflow

  assign at_depth = (count == boxcar_pkg::count_t'(DEPTH));

  // running sum register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum <= '0;
    end else if (cap.flush) begin
      sum <= '0;                                   // window emptied with the line
    end else if (cap.shift) begin
      sum <= sum_d;
    end
  end

  // fill counter, stops at DEPTH and stays there
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (cap.flush) begin
      count <= '0;                                 // refill starts over
    end else if (cap.shift && !at_depth) begin
      count <= count + boxcar_pkg::count_t'(1);
    end
  end

  // level output, high from the DEPTH-th shift on
  assign full = at_depth;

  // before the window is full the empty stages are zero, so the
  // sum is still exact, just over fewer real samples

  // SUM_W leaves 5 bits of headroom, enough for 32 samples of 0xffff

  // no division, the caller scales the sum if an average is wanted

  // idle cycles keep sum and count, matching the held delay line

  // count_t is 6 bits so DEPTH=32 compares without truncation

  // both registers change on the same edge as srl_delay, so oldest
  // is always the value about to be dropped from the sum

endmodule

//--- design/boxcar_filter.sv
`timescale 1ns/1ns

module boxcar_filter #(
  parameter int DEPTH = 8                 // window length, 2..MAX_DEPTH
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en,         // valid sample on din
  input  logic                clr,        // flush the window, beats en
  input  boxcar_pkg::sample_t din,
  output boxcar_pkg::sample_t dout,       // sample from DEPTH-1 shifts earlier
  output boxcar_pkg::sum_t    sum,        // sum of the current window
  output logic                full        // DEPTH samples in since reset or clr
);

  boxcar_pkg::capture_t cap;              // registered input cycle, fans out to both
  boxcar_pkg::sample_t  oldest;           // leaving sample, line to sum

  // producer, registers pins into one struct
  sample_capture i_sample_capture (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .clr   (clr),
    .din   (din),
    .cap   (cap)
  );

  // buffer, enable-gated delay line
  srl_delay #(
    .DEPTH (DEPTH)
  ) i_srl_delay (
    .clk    (clk),
    .rst_n  (rst_n),
    .cap    (cap),
    .oldest (oldest),
    .dout   (dout)
  );

  // consumer, running sum and fill level
  window_sum #(
    .DEPTH (DEPTH)
  ) i_window_sum (
    .clk    (clk),
    .rst_n  (rst_n),
    .cap    (cap),
    .oldest (oldest),
    .sum    (sum),
    .full   (full)
  );

  // two edges from a pin sample to dout, sum and full:
  // one in the capture stage, one in the line and the sum

endmodule

//--- tb/boxcar_filter_sva.sv
`timescale 1ns/1ns

module boxcar_filter_sva (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 en,
  input logic                 clr,
  input boxcar_pkg::capture_t cap,     // internal capture struct of the top level
  input boxcar_pkg::sum_t     sum,
  input logic                 full
);

  // full only goes up on the edge that applies a shift
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(full) |-> $past(cap.shift))
  else $error("full rose without a shift in the previous cycle");

  // a cycle with neither en nor clr shows up as a quiet sum 2 edges later
  assert property (@(posedge clk) disable iff (!rst_n)
    $past(!en && !clr, 2) |-> $stable(sum))
  else $error("sum changed after a cycle without en or clr");

  // flush reaches sum and full after the capture stage and the update edge
  assert property (@(posedge clk) disable iff (!rst_n)
    $past(clr, 2) |-> (sum == '0 && !full))
  else $error("sum or full not cleared 2 cycles after clr");

endmodule

// attach to every boxcar_filter, reaches the internal cap wire
bind boxcar_filter boxcar_filter_sva i_boxcar_filter_sva (
  .clk   (clk),
  .rst_n (rst_n),
  .en    (en),
  .clr   (clr),
  .cap   (cap),
  .sum   (sum),
  .full  (full)
);

//--- tb/boxcar_filter_tb.sv
`timescale 1ns/1ns

module boxcar_filter_tb;

  localparam int DEPTH      = 8;                  // window length under test
  localparam int CLK_PERIOD = 4;                  // ns
  localparam int RST_CYC    = 2;
  localparam int N_STREAM   = 48;                 // enabled samples in the stream test
  localparam int N_GAPS     = 64;                 // cycles in the gapped test
  // stimulus cycles of each test in the sequence below
  localparam int TOTAL_CYC  = RST_CYC + 4 + (N_STREAM + 3) + (N_GAPS + 3)
                            + (DEPTH + 11) + (DEPTH + 21) + (DEPTH + 8);
  localparam int TIMEOUT_NS = (TOTAL_CYC + 50) * CLK_PERIOD;

  logic                clk;
  logic                rst_n;
  logic                en;
  logic                clr;
  boxcar_pkg::sample_t din;
  boxcar_pkg::sample_t dout;
  boxcar_pkg::sum_t    sum;
  logic                full;

  int seed;                                       // $random state
  int cmp_pass;                                   // counts of the compare process
  int cmp_err;
  int tst_pass;                                   // counts of the direct checks in tests
  int tst_err;

  boxcar_pkg::sample_t model_q[$];                // index 0 is the newest sample
  int                  model_sum;
  int                  model_cnt;                 // shifts since reset or clr, saturating

  logic                en_d1;                     // inputs seen one negedge ago
  logic                clr_d1;
  boxcar_pkg::sample_t din_d1;
  logic                en_d2;                     // inputs from two negedges ago
  logic                clr_d2;
  boxcar_pkg::sample_t din_d2;

  boxcar_filter #(
    .DEPTH (DEPTH)
  ) i_boxcar_filter (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .clr   (clr),
    .din   (din),
    .dout  (dout),
    .sum   (sum),
    .full  (full)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // empty window with all stages at zero
  function automatic void model_reset();
    model_q.delete();
    for (int i = 0; i < DEPTH; i++) begin
      model_q.push_back('0);
    end
    model_sum = 0;
    model_cnt = 0;
  endfunction

  // apply one input cycle to the window where clr beats en
  function automatic void model_step(input logic e, input logic c,
                                     input boxcar_pkg::sample_t d);
    int acc;
    if (c) begin
      foreach (model_q[i]) model_q[i] = '0;       // flush drops the sample of this cycle
      model_cnt = 0;
    end else if (e) begin
      model_q.push_front(d);                      // newest in and oldest out
      void'(model_q.pop_back());
      if (model_cnt < DEPTH) model_cnt++;
    end
    acc = 0;
    foreach (model_q[i]) acc += int'(model_q[i]); // sum over the whole window
    model_sum = acc;
  endfunction

  function automatic bit check_value(input string name, input logic [31:0] expected,
                                     input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] time %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // outputs and inputs are both stable at the falling edge
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      model_reset();
      en_d1  = 1'b0;
      clr_d1 = 1'b0;
      din_d1 = '0;
      en_d2  = 1'b0;
      clr_d2 = 1'b0;
      din_d2 = '0;
    end else begin
      model_step(en_d2, clr_d2, din_d2);          // 2 cycles of latency
      if (check_value("dout", 32'(model_q[DEPTH-1]), 32'(dout))) cmp_pass++;
      else cmp_err++;
      if (check_value("sum", model_sum, 32'(sum))) cmp_pass++;
      else cmp_err++;
      if (check_value("full", 32'(model_cnt == DEPTH), 32'(full))) cmp_pass++;
      else cmp_err++;
      en_d2  = en_d1;
      clr_d2 = clr_d1;
      din_d2 = din_d1;
      en_d1  = en;
      clr_d1 = clr;
      din_d1 = din;
    end
  end

  task automatic drive(input logic e, input logic c, input boxcar_pkg::sample_t d);
    @(posedge clk);
    #1;                                           // small hold after the edge
    en  = e;
    clr = c;
    din = d;
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, 1'b0, din);
  endtask

  task automatic expect_now(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (check_value(name, expected, actual)) tst_pass++;
    else tst_err++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = cmp_err + tst_err - errs_before;
    $display("test %s finished: %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  initial begin
    int errs_before;
    seed     = 24;
    cmp_pass = 0;
    cmp_err  = 0;
    tst_pass = 0;
    tst_err  = 0;
    rst_n = 1'b0;
    en = 1'b0;
    clr = 1'b0;
    din = '0;
    repeat (RST_CYC) @(posedge clk);
    #1 rst_n = 1'b1;

    errs_before = cmp_err + tst_err;              // outputs idle at zero after reset
    idle(2);
    expect_now("dout", 32'h0, 32'(dout));
    expect_now("sum", 32'h0, 32'(sum));
    expect_now("full", 32'h0, 32'(full));
    idle(2);
    report_test("reset_state", errs_before);

    errs_before = cmp_err + tst_err;              // back-to-back samples
    repeat (N_STREAM) drive(1'b1, 1'b0, boxcar_pkg::sample_t'($random(seed)));
    idle(3);
    report_test("continuous_stream", errs_before);

    errs_before = cmp_err + tst_err;              // en low about half the time
    repeat (N_GAPS) drive(1'($random(seed)), 1'b0, boxcar_pkg::sample_t'($random(seed)));
    idle(3);
    report_test("gapped_stream", errs_before);

    errs_before = cmp_err + tst_err;              // full after exactly DEPTH shifts
    drive(1'b0, 1'b1, din);
    repeat (DEPTH - 1) drive(1'b1, 1'b0, boxcar_pkg::sample_t'($random(seed)));
    idle(2);
    expect_now("full", 32'h0, 32'(full));
    drive(1'b1, 1'b0, boxcar_pkg::sample_t'($random(seed)));
    idle(2);
    expect_now("full", 32'h1, 32'(full));
    repeat (4) drive(1'b1, 1'b0, boxcar_pkg::sample_t'($random(seed)));
    idle(2);
    expect_now("full", 32'h1, 32'(full));         // stays high
    report_test("full_rise", errs_before);

    errs_before = cmp_err + tst_err;              // flush mid-stream
    repeat (12) drive(1'b1, 1'b0, boxcar_pkg::sample_t'($random(seed)));
    drive(1'b1, 1'b1, boxcar_pkg::sample_t'($random(seed))); // en with clr drops the sample
    idle(2);
    expect_now("dout", 32'h0, 32'(dout));
    expect_now("sum", 32'h0, 32'(sum));
    expect_now("full", 32'h0, 32'(full));
    repeat (DEPTH + 2) drive(1'b1, 1'b0, boxcar_pkg::sample_t'($random(seed)));
    drive(1'b0, 1'b1, din);                       // clr alone
    idle(2);
    expect_now("dout", 32'h0, 32'(dout));
    expect_now("sum", 32'h0, 32'(sum));
    expect_now("full", 32'h0, 32'(full));
    idle(1);
    report_test("clear_mid_stream", errs_before);

    errs_before = cmp_err + tst_err;              // all ones must not wrap the sum
    drive(1'b0, 1'b1, din);
    repeat (DEPTH + 4) drive(1'b1, 1'b0, 16'hffff);
    idle(2);
    expect_now("sum", DEPTH * 65535, 32'(sum));
    expect_now("dout", 32'hffff, 32'(dout));
    expect_now("full", 32'h1, 32'(full));
    idle(1);
    report_test("full_scale", errs_before);

    $display("checks passed: %0d, errors: %0d", cmp_pass + tst_pass, cmp_err + tst_err);
    if (cmp_err + tst_err == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // run length is fixed by the test budget above
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- boxcar_filter.f
design/boxcar_pkg.sv
design/sample_capture.sv
design/srl_delay.sv
design/window_sum.sv
design/boxcar_filter.sv
tb/boxcar_filter_sva.sv
tb/boxcar_filter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the boxcar filter testbench with Verilator.
# Exit status is 0 on pass, 1 on fail.

set -u

cd "$(dirname "$0")" || exit 1

TOP=boxcar_filter_tb
FILE_LIST=boxcar_filter.f
OBJ_DIR=obj_dir
BIN_NAME=boxcar_filter_sim
LOG=sim.log
FAIL_MSG="Simulation finished: FAIL"

rm -rf "$OBJ_DIR" "$LOG"

echo "building $TOP"
verilator --binary --assert -j 0 \
  --top-module "$TOP" \
  -f "$FILE_LIST" \
  --Mdir "$OBJ_DIR" \
  -o "$BIN_NAME"
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

echo "running simulation, log in $LOG"
"./$OBJ_DIR/$BIN_NAME" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "run failed, see $LOG"
  exit 1
fi

echo "run passed"
exit 0
